// File: Makefile
# Verilator build and run of the ADC subsystem testbench.
VERILATOR ?= verilator
TOP       ?= tb_adc_subsystem
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
FAIL_MSG  ?= TESTBENCH FAILED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails on a nonzero exit or when the log holds the fail message.
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; \
	status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
design/adc_pkg.sv
design/sample_if.sv
design/adc_serial_reader.sv
design/sample_fifo.sv
design/adc_apb_regs.sv
design/adc_subsystem_top.sv
tests/adc_model.sv
tests/tb_adc_subsystem.sv

// File: design/adc_apb_regs.sv
// APB register block without wait states; a DATA read pops the FIFO in its access cycle.
`timescale 1ns/1ps

module adc_apb_regs #(
    parameter int                fifo_depth = 8,
    parameter adc_pkg::clk_div_t div_reset  = 8'd3
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  adc_pkg::apb_addr_t           paddr,
    input  adc_pkg::apb_data_t           pwdata,
    output adc_pkg::apb_data_t           prdata,
    output logic                         pready,
    output logic                         pslverr,
    output logic                         enable,
    output adc_pkg::clk_div_t            clk_div,
    output logic                         pop,
    output logic                         overrun_clr,
    input  adc_pkg::sample_t             head_data,
    input  logic                         head_err,
    input  logic [$clog2(fifo_depth):0]  count,
    input  logic                         empty,
    input  logic                         full,
    input  logic                         overrun
);
    import adc_pkg::*;

    logic      access;
    logic      rd;
    logic      wr;
    logic      hit_ctrl;
    logic      hit_status;
    logic      hit_data;
    logic      bad_addr;
    apb_data_t ctrl_word;
    apb_data_t status_word;
    apb_data_t data_word;
    apb_data_t rdata;

    assign pready = 1'b1;

    // access phase lasts one cycle since there are no wait states.
    assign access = psel && penable;
    assign rd     = access && !pwrite;
    assign wr     = access && pwrite;

    assign hit_ctrl   = (paddr == ctrl_addr);
    assign hit_status = (paddr == status_addr);
    assign hit_data   = (paddr == data_addr);
    assign bad_addr   = !(hit_ctrl || hit_status || hit_data);

    assign ctrl_word   = {16'b0, clk_div, 7'b0, enable};
    assign status_word = {21'b0, overrun, full, empty, 8'(count)};
    assign data_word   = {15'b0, head_err, 4'b0, head_data};

    always_comb begin
        rdata = '0;
        case (1'b1)
            hit_ctrl:   rdata = ctrl_word;
            hit_status: rdata = status_word;
            // an empty FIFO reads as zero.
            hit_data:   rdata = empty ? '0 : data_word;
            default:    rdata = '0;
        endcase
    end

    assign prdata  = rd ? rdata : '0;
    assign pslverr = access && (bad_addr || (rd && hit_data && empty));

    assign pop         = rd && hit_data && !empty;
    assign overrun_clr = wr && hit_status && pwdata[10];

    // CTRL takes effect the cycle after the access phase.
    always_ff @(posedge clk) begin
        if (rst) begin
            enable  <= 1'b0;
            clk_div <= div_reset;
        end else if (wr && hit_ctrl) begin
            enable  <= pwdata[0];
            clk_div <= pwdata[15:8];
        end
    end

    assert property (@(posedge clk) disable iff (rst) penable |-> psel);

endmodule

// File: design/adc_pkg.sv
// shared types and register map of the ADC subsystem; offsets assume a 4-bit byte-addressed APB window.
package adc_pkg;

    // one converted value and one raw serial frame.
    typedef logic [11:0] sample_t;
    typedef logic [15:0] frame_t;

    // sclk half period in clk cycles minus one.
    typedef logic [7:0] clk_div_t;

    typedef logic [3:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    localparam apb_addr_t ctrl_addr   = 4'h0;
    localparam apb_addr_t status_addr = 4'h4;
    localparam apb_addr_t data_addr   = 4'h8;

    // bits per serial frame, leading zeros included.
    localparam int frame_bits = 16;

    typedef enum logic [1:0] {
        idle,
        quiet,
        shift,
        done
    } reader_state_t;

endpackage

// File: design/adc_serial_reader.sv
// AD7476A-style frame reader; clk_div 0 gives sclk at clk/2, cs stays high two sclk periods between frames.
`timescale 1ns/1ps

module adc_serial_reader (
    input  logic              clk,
    input  logic              rst,
    input  logic              enable,
    input  adc_pkg::clk_div_t clk_div,
    input  logic              data_in,
    output logic              cs,
    output logic              sclk,
    sample_if.source          smp
);
    import adc_pkg::*;

    reader_state_t state;
    clk_div_t      div_q;
    clk_div_t      hcnt;
    logic [4:0]    bcnt;
    logic          half_end;
    logic          rise;
    logic          rise_q;
    logic          frame_end;
    logic          din_q;
    frame_t        shreg;

    assign half_end = (hcnt == '0);

    // sclk is about to go high at the end of this cycle.
    assign rise = (state == shift) && half_end && (bcnt != '0) && !sclk;

    // bcnt counts half periods left in the current phase.
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            cs        <= 1'b1;
            sclk      <= 1'b0;
            div_q     <= '0;
            hcnt      <= '0;
            bcnt      <= '0;
            rise_q    <= 1'b0;
            frame_end <= 1'b0;
            smp.valid <= 1'b0;
        end else begin
            rise_q    <= rise;
            frame_end <= 1'b0;
            smp.valid <= frame_end;
            case (state)
                idle: begin
                    if (enable) begin
                        // divider is latched once per frame.
                        div_q <= clk_div;
                        hcnt  <= clk_div;
                        bcnt  <= 5'd1;
                        state <= quiet;
                    end
                end
                quiet: begin
                    if (!half_end) begin
                        hcnt <= hcnt - 1'b1;
                    end else if (bcnt != '0) begin
                        hcnt <= div_q;
                        bcnt <= bcnt - 1'b1;
                    end else begin
                        hcnt  <= div_q;
                        bcnt  <= 5'(2 * frame_bits - 1);
                        cs    <= 1'b0;
                        state <= shift;
                    end
                end
                shift: begin
                    if (!half_end) begin
                        hcnt <= hcnt - 1'b1;
                    end else if (bcnt != '0) begin
                        hcnt <= div_q;
                        bcnt <= bcnt - 1'b1;
                        sclk <= ~sclk;
                    end else begin
                        // last high half ends here.
                        hcnt      <= div_q;
                        bcnt      <= 5'd1;
                        sclk      <= 1'b0;
                        cs        <= 1'b1;
                        frame_end <= 1'b1;
                        state     <= done;
                    end
                end
                done: begin
                    if (!half_end) begin
                        hcnt <= hcnt - 1'b1;
                    end else if (bcnt != '0) begin
                        hcnt <= div_q;
                        bcnt <= bcnt - 1'b1;
                    end else if (enable) begin
                        div_q <= clk_div;
                        hcnt  <= clk_div;
                        bcnt  <= 5'd1;
                        state <= quiet;
                    end else begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // data_in is registered once and shifted in on the first high cycle of sclk.
    always_ff @(posedge clk) begin
        din_q <= data_in;
        if (rise_q) begin
            shreg <= {shreg[frame_bits-2:0], din_q};
        end
        if (frame_end) begin
            smp.data      <= shreg[$bits(sample_t)-1:0];
            smp.frame_err <= |shreg[frame_bits-1:$bits(sample_t)];
        end
    end

    // chip select holds steady for the whole shift window.
    assert property (@(posedge clk) disable iff (rst)
        (state == shift && $past(state) == shift) |-> $stable(cs));

    assert property (@(posedge clk) disable iff (rst)
        smp.valid |=> !smp.valid);

endmodule

// File: design/adc_subsystem_top.sv
// single-clock ADC subsystem; APB never waits and the serial pins connect straight to the converter.
`timescale 1ns/1ps

module adc_subsystem_top #(
    parameter int                fifo_depth = 8,
    parameter adc_pkg::clk_div_t div_reset  = 8'd3
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  adc_pkg::apb_addr_t paddr,
    input  adc_pkg::apb_data_t pwdata,
    output adc_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,
    output logic               cs,
    output logic               sclk,
    input  logic               data_in
);
    import adc_pkg::*;

    logic                        enable;
    clk_div_t                    clk_div;
    logic                        pop;
    logic                        overrun_clr;
    sample_t                     head_data;
    logic                        head_err;
    logic [$clog2(fifo_depth):0] count;
    logic                        empty;
    logic                        full;
    logic                        overrun;

    sample_if smp_if ();

    adc_apb_regs #(
        .fifo_depth (fifo_depth),
        .div_reset  (div_reset)
    ) u_regs (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .enable      (enable),
        .clk_div     (clk_div),
        .pop         (pop),
        .overrun_clr (overrun_clr),
        .head_data   (head_data),
        .head_err    (head_err),
        .count       (count),
        .empty       (empty),
        .full        (full),
        .overrun     (overrun)
    );

    adc_serial_reader u_reader (
        .clk     (clk),
        .rst     (rst),
        .enable  (enable),
        .clk_div (clk_div),
        .data_in (data_in),
        .cs      (cs),
        .sclk    (sclk),
        .smp     (smp_if.source)
    );

    sample_fifo #(
        .fifo_depth (fifo_depth)
    ) u_fifo (
        .clk         (clk),
        .rst         (rst),
        .smp         (smp_if.sink),
        .pop         (pop),
        .head_data   (head_data),
        .head_err    (head_err),
        .count       (count),
        .empty       (empty),
        .full        (full),
        .overrun     (overrun),
        .overrun_clr (overrun_clr)
    );

endmodule

// File: design/sample_fifo.sv
// show-ahead sample FIFO; fifo_depth must be a power of two, at least 2; drops set a sticky overrun.
`timescale 1ns/1ps

module sample_fifo #(
    parameter int fifo_depth = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    sample_if.sink                       smp,
    input  logic                         pop,
    output adc_pkg::sample_t             head_data,
    output logic                         head_err,
    output logic [$clog2(fifo_depth):0]  count,
    output logic                         empty,
    output logic                         full,
    output logic                         overrun,
    input  logic                         overrun_clr
);
    import adc_pkg::*;

    localparam int aw = $clog2(fifo_depth);
    localparam int cw = aw + 1;

    sample_t         mem_data [fifo_depth];
    logic            mem_err  [fifo_depth];
    logic [aw-1:0]   wptr;
    logic [aw-1:0]   rptr;
    logic            push;
    logic            do_pop;

    assign full      = (count == cw'(fifo_depth));
    assign empty     = (count == '0);
    assign smp.ready = ~full;
    assign push      = smp.valid && smp.ready;
    assign do_pop    = pop && !empty;

    assign head_data = mem_data[rptr];
    assign head_err  = mem_err[rptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem_data[wptr] <= smp.data;
            mem_err[wptr]  <= smp.frame_err;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wptr    <= '0;
            rptr    <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end else begin
            if (push) wptr <= wptr + 1'b1;
            if (do_pop) rptr <= rptr + 1'b1;
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // a drop in the same cycle as a clear wins.
            if (smp.valid && !smp.ready) overrun <= 1'b1;
            else if (overrun_clr) overrun <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

// File: design/sample_if.sv
// one sample handshake from reader to FIFO; the source never stalls, so a low ready means a drop.
`timescale 1ns/1ps

interface sample_if;
    import adc_pkg::*;

    logic    valid;
    logic    ready;
    sample_t data;
    logic    frame_err;

    modport source (
        output valid, data, frame_err,
        input  ready
    );

    modport sink (
        input  valid, data, frame_err,
        output ready
    );

endinterface

// File: tests/adc_model.sv
// behavioural serial converter; an empty queue sends all-zero frames, one frame per cs-low window.
`timescale 1ns/1ps

module adc_model (
    input  logic cs,
    input  logic sclk,
    output logic data_in
);
    import adc_pkg::*;

    frame_t frames [$];

    // queues one frame for a later cs-low window.
    task automatic send(input frame_t f);
        frames.push_back(f);
    endtask

    initial begin
        frame_t f;
        data_in = 1'b0;
        forever begin
            @(negedge cs);
            f = (frames.size() != 0) ? frames.pop_front() : '0;
            // MSB goes out as cs falls, the rest on sclk falling edges.
            data_in <= f[frame_bits-1];
            for (int i = frame_bits - 2; i >= 0; i--) begin
                @(negedge sclk);
                data_in <= f[i];
            end
        end
    end

endmodule

// File: tests/tb_adc_subsystem.sv
// testbench for adc_subsystem_top with a 4-entry FIFO; expects the converter model on the serial pins.
`timescale 1ns/1ps

module tb_adc_subsystem;
    import adc_pkg::*;

    localparam int       depth     = 4;
    localparam clk_div_t div_reset = 8'd3;
    localparam int       n_rows    = 4;

    typedef struct packed {
        clk_div_t div;
        int       frames;
        logic     bad_lead;
    } row_t;

    logic      clk;
    logic      rst;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    logic      cs;
    logic      sclk;
    logic      data_in;

    row_t     stim [n_rows];
    frame_t   exp_q [$];
    clk_div_t cur_div;
    int       errors;
    int       cycles;
    int       cycle_limit;
    int       frames_started;
    int       frames_done;
    int       hi_cnt;
    int       rises;
    logic     prev_cs;
    logic     prev_sclk;

    adc_subsystem_top #(
        .fifo_depth (depth),
        .div_reset  (div_reset)
    ) dut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cs      (cs),
        .sclk    (sclk),
        .data_in (data_in)
    );

    adc_model model (
        .cs      (cs),
        .sclk    (sclk),
        .data_in (data_in)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_sample(input string name, input sample_t exp, input sample_t act);
        if (exp !== act) begin
            $display("ERROR at %0t: %s expected %03h got %03h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERROR at %0t: %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input apb_data_t exp, input apb_data_t act);
        if (exp !== act) begin
            $display("ERROR at %0t: %s expected %08h got %08h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("ERROR at %0t: %s expected %0d got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    // pready and pslverr are sampled mid access phase.
    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        check_flag("pready on write", 1'b1, pready);
        check_flag("pslverr on write", 1'b0, pslverr);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // prdata, pslverr and pready are sampled mid access phase.
    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        check_flag("pready on read", 1'b1, pready);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // measures sclk high time and rising edges per cs-low window.
    always @(posedge clk) begin
        if (rst) begin
            prev_cs   = 1'b1;
            prev_sclk = 1'b0;
            hi_cnt    = 0;
            rises     = 0;
        end else begin
            if (sclk) begin
                hi_cnt++;
            end else if (prev_sclk) begin
                check_count("sclk high cycles", int'(cur_div) + 1, hi_cnt);
                hi_cnt = 0;
            end
            if (!cs && sclk && !prev_sclk) rises++;
            if (prev_cs && !cs) frames_started <= frames_started + 1;
            if (!prev_cs && cs) begin
                check_count("sclk rises per frame", frame_bits, rises);
                rises = 0;
                frames_done <= frames_done + 1;
            end
            prev_cs   = cs;
            prev_sclk = sclk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, converter frames did not complete", cycles);
            $display("%0d errors before the timeout", errors);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // sends n frames, stops the reader, then checks STATUS and drains DATA.
    task automatic run_row(input row_t r);
        frame_t    f;
        apb_data_t rd;
        logic      err;
        int        start_base;
        int        done_base;
        int        cnt;
        for (int i = 0; i < r.frames; i++) begin
            f[11:0]  = 12'($urandom());
            f[15:12] = r.bad_lead ? 4'($urandom_range(15, 1)) : 4'h0;
            model.send(f);
            exp_q.push_back(f);
        end
        cur_div    = r.div;
        start_base = frames_started;
        done_base  = frames_done;
        apb_write(ctrl_addr, {16'b0, r.div, 7'b0, 1'b1});
        while (frames_started < start_base + r.frames) @(posedge clk);
        apb_write(ctrl_addr, {16'b0, r.div, 8'b0});
        while (frames_done < done_base + r.frames) @(posedge clk);
        // valid follows cs by one cycle and the push lands one cycle later.
        repeat (2) @(posedge clk);
        cnt = (r.frames < depth) ? r.frames : depth;
        apb_read(status_addr, rd, err);
        check_word("STATUS after frames",
                   {21'b0, r.frames > depth, cnt == depth, cnt == 0, 8'(cnt)}, rd);
        for (int i = 0; i < cnt; i++) begin
            apb_read(data_addr, rd, err);
            check_flag("pslverr on DATA", 1'b0, err);
            check_sample("DATA sample", exp_q[i][11:0], rd[11:0]);
            check_flag("DATA frame_err", |exp_q[i][15:12], rd[16]);
        end
        apb_write(status_addr, 32'h0000_0400);
        apb_read(status_addr, rd, err);
        check_word("STATUS after drain", 32'h0000_0100, rd);
        exp_q.delete();
    endtask

    initial begin
        apb_data_t rd;
        logic      err;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        rst            = 1'b1;
        errors         = 0;
        cycles         = 0;
        frames_started = 0;
        frames_done    = 0;
        cur_div        = div_reset;
        void'($urandom(32'h1bd7_0740));

        // clk_div, frames, leading bits nonzero.
        stim[0] = '{div: 8'd1, frames: 3, bad_lead: 1'b0};
        stim[1] = '{div: 8'd3, frames: 2, bad_lead: 1'b1};
        stim[2] = '{div: 8'd0, frames: 6, bad_lead: 1'b0};
        stim[3] = '{div: 8'd2, frames: 2, bad_lead: 1'b0};

        cycle_limit = 0;
        for (int i = 0; i < n_rows; i++) begin
            cycle_limit += stim[i].frames * (36 * (int'(stim[i].div) + 1) + 1);
        end
        cycle_limit = cycle_limit + cycle_limit / 5 + 200;

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        check_flag("cs while disabled", 1'b1, cs);
        check_flag("sclk while disabled", 1'b0, sclk);
        apb_read(ctrl_addr, rd, err);
        check_word("CTRL reset value", {16'b0, div_reset, 8'b0}, rd);
        apb_read(status_addr, rd, err);
        check_word("STATUS reset value", 32'h0000_0100, rd);

        for (int i = 0; i < n_rows; i++) begin
            run_row(stim[i]);
        end

        apb_read(data_addr, rd, err);
        check_flag("pslverr on empty DATA", 1'b1, err);
        check_word("DATA while empty", '0, rd);
        apb_read(4'hC, rd, err);
        check_flag("pslverr on unknown address", 1'b1, err);

        $display("run complete: %0d errors", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
